// File: common/rotator_cfg_pkg.sv
`default_nettype none

package rotator_cfg_pkg;

  // Weight and beat geometry
  localparam int WORD_WIDTH = 8;
  localparam int COLS       = 4;
  localparam int S_WIDTH    = 16;
  localparam int M_WIDTH    = WORD_WIDTH * COLS;

  // Tensor size limits
  localparam int KW_MAX     = 7;
  localparam int CI_MAX     = 4;
  localparam int XW_MAX     = 8;
  localparam int BLOCKS_MAX = 4;
  localparam int XN_MAX     = 2;
  localparam int RAM_DEPTH  = 32;

  localparam int BITS_KW2    = $clog2((KW_MAX + 1) / 2);
  localparam int BITS_KW     = $clog2(KW_MAX);
  localparam int BITS_CI     = $clog2(CI_MAX);
  localparam int BITS_XW     = $clog2(XW_MAX);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX);
  localparam int BITS_XN     = $clog2(XN_MAX);
  localparam int BITS_ADDR   = $clog2(RAM_DEPTH);

  // Packed into the first beat of every tensor
  typedef struct packed {
    logic [BITS_ADDR-1:0]   addr_max;
    logic [BITS_XN-1:0]     xn_1;
    logic [BITS_BLOCKS-1:0] blocks_1;
    logic [BITS_XW-1:0]     cols_1;
    logic [BITS_CI-1:0]     cin_1;
    logic [BITS_KW2-1:0]    kw2;
  } rotation_cfg_t;

endpackage

`default_nettype wire

// File: common/rotator_stream_pkg.sv
`default_nettype none

package rotator_stream_pkg;

  localparam int PIXEL_WIDTH = 32;

  // Sideband flags that follow each weight word
  typedef struct packed {
    logic                                 is_config;
    logic [rotator_cfg_pkg::BITS_KW2-1:0] kw2;
    logic                                 is_w_first_clk;
    logic                                 is_cin_last;
    logic                                 is_w_first_kw2;
    logic                                 is_w_last;
  } w_user_t;

  typedef struct packed {
    logic [rotator_cfg_pkg::M_WIDTH-1:0] data;
    logic                                last;
    w_user_t                             user;
  } w_beat_t;

  // Weight word paired with one pixel beat
  typedef struct packed {
    logic [rotator_cfg_pkg::M_WIDTH-1:0] weights;
    logic [PIXEL_WIDTH-1:0]              pixels;
    logic                                last;
    w_user_t                             user;
  } conv_beat_t;

endpackage

`default_nettype wire

// File: source/weight_width_adapter.sv
`default_nettype none

module weight_width_adapter (
  input  wire                                  aclk,
  input  wire                                  aresetn,
  input  wire                                  i_valid,
  output logic                                 o_ready,
  input  wire  [rotator_cfg_pkg::S_WIDTH-1:0]  i_data,
  input  wire                                  i_last,
  output logic                                 o_valid,
  input  wire                                  i_ready,
  output logic [rotator_cfg_pkg::M_WIDTH-1:0]  o_data,
  output logic                                 o_last
);

  localparam int SW = rotator_cfg_pkg::S_WIDTH;

  logic          have_low;
  logic          full;
  logic [SW-1:0] low_half;
  logic [SW-1:0] high_half;
  logic          last_q;

  wire in_fire  = i_valid && o_ready;
  wire out_fire = o_valid && i_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      have_low <= 1'b0;
      full     <= 1'b0;
    end else begin
      if (in_fire) begin
        have_low <= !have_low;
        if (have_low) begin
          full <= 1'b1;
        end
      end else if (out_fire) begin
        full <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge aclk) begin
    if (in_fire) begin
      if (!have_low) begin
        low_half <= i_data;
      end else begin
        high_half <= i_data;
        last_q    <= i_last;
      end
    end
  end

  assign o_ready = !full;
  assign o_valid = full;
  assign o_data  = {high_half, low_half};
  assign o_last  = last_q;

endmodule

`default_nettype wire

// File: source/cyclic_bram.sv
`default_nettype none

module cyclic_bram #(
  parameter int DEPTH    = 32,
  parameter int WIDTH    = 32,
  parameter int LATENCY  = 2,
  parameter int ADDR_MIN = 1
) (
  input  wire                        aclk,
  input  wire                        aresetn,
  input  wire                        i_clear,
  input  wire                        i_wen,
  input  wire  [WIDTH-1:0]           i_wdata,
  input  wire                        i_ren,
  input  wire  [$clog2(DEPTH)-1:0]   i_addr_max,
  output logic [WIDTH-1:0]           o_rdata
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] pipe [LATENCY];
  logic [AW-1:0]    wptr;
  logic [AW-1:0]    rptr;

  always_ff @(posedge aclk) begin
    if (!aresetn || i_clear) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (i_wen) begin
        wptr <= wptr + 1'b1;
      end
      // Config word is read once, data words wrap
      if (i_ren) begin
        rptr <= (rptr >= i_addr_max) ? AW'(ADDR_MIN) : rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wen) begin
      mem[wptr] <= i_wdata;
    end
    if (i_ren) begin
      pipe[0] <= mem[rptr];
    end
    for (int i = 1; i < LATENCY; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign o_rdata = pipe[LATENCY-1];

endmodule

`default_nettype wire

// File: source/rotation_counters.sv
`default_nettype none

module rotation_counters (
  input  wire                                aclk,
  input  wire rotator_cfg_pkg::rotation_cfg_t i_load,
  input  wire                                i_start,
  input  wire                                i_step,
  output logic                               o_last,
  output rotator_stream_pkg::w_user_t        o_user
);

  rotator_cfg_pkg::rotation_cfg_t cfg;

  logic [rotator_cfg_pkg::BITS_KW-1:0]     c_kw;
  logic [rotator_cfg_pkg::BITS_CI-1:0]     c_ci;
  logic [rotator_cfg_pkg::BITS_XW-1:0]     c_cols;
  logic [rotator_cfg_pkg::BITS_BLOCKS-1:0] c_blocks;
  logic [rotator_cfg_pkg::BITS_XN-1:0]     c_xn;

  // Kernel counter runs 0 .. 2*kw2
  wire l_kw     = c_kw == rotator_cfg_pkg::BITS_KW'({cfg.kw2, 1'b0});
  wire l_ci     = c_ci == cfg.cin_1;
  wire l_cols   = c_cols == cfg.cols_1;
  wire l_blocks = c_blocks == cfg.blocks_1;
  wire l_xn     = c_xn == cfg.xn_1;

  wire w_ci     = l_kw && l_ci;
  wire w_cols   = w_ci && l_cols;
  wire w_blocks = w_cols && l_blocks;

  always_ff @(posedge aclk) begin
    if (i_start) begin
      cfg      <= i_load;
      c_kw     <= '0;
      c_ci     <= '0;
      c_cols   <= '0;
      c_blocks <= '0;
      c_xn     <= '0;
    end else if (i_step) begin
      c_kw <= l_kw ? '0 : c_kw + 1'b1;
      if (l_kw) begin
        c_ci <= l_ci ? '0 : c_ci + 1'b1;
      end
      if (w_ci) begin
        c_cols <= l_cols ? '0 : c_cols + 1'b1;
      end
      if (w_cols) begin
        c_blocks <= l_blocks ? '0 : c_blocks + 1'b1;
      end
      if (w_blocks) begin
        c_xn <= l_xn ? '0 : c_xn + 1'b1;
      end
    end
  end

  assign o_last = w_blocks && l_xn;

  always_comb begin
    o_user                = '0;
    o_user.kw2            = cfg.kw2;
    o_user.is_w_first_clk = (c_kw == '0) && (c_ci == '0) && (c_cols == '0);
    o_user.is_cin_last    = w_ci;
    o_user.is_w_first_kw2 = (cfg.cols_1 - c_cols) < rotator_cfg_pkg::BITS_XW'(cfg.kw2);
    o_user.is_w_last      = l_cols;
  end

endmodule

`default_nettype wire

// File: weight_rotator/weight_rotator.sv
`default_nettype none

module weight_rotator #(
  parameter int CONFIG_BEATS = 1,
  parameter int RAM_LATENCY  = 2
) (
  input  wire                                  aclk,
  input  wire                                  aresetn,
  input  wire                                  i_s_valid,
  output logic                                 o_s_ready,
  input  wire  [rotator_cfg_pkg::S_WIDTH-1:0]  i_s_data,
  input  wire                                  i_s_last,
  output logic                                 o_w_valid,
  input  wire                                  i_w_ready,
  output rotator_stream_pkg::w_beat_t          o_w_beat,
  input  wire                                  i_w_slots_free
);

  localparam int MW = rotator_cfg_pkg::M_WIDTH;

  typedef enum logic [2:0] {W_IDLE, W_GET_REF, W_WRITE, W_FILL, W_SWITCH} write_state_t;
  typedef enum logic [1:0] {R_IDLE, R_PASS_CONFIG, R_READ, R_SWITCH} read_state_t;
  typedef enum logic {DW_BLOCK, DW_PASS} split_state_t;

  // Tag that travels alongside each RAM read
  typedef struct packed {
    logic                        valid;
    logic                        bank;
    logic                        last;
    rotator_stream_pkg::w_user_t user;
  } read_tag_t;

  write_state_t state_write;
  read_state_t  state_read;
  split_state_t state_dw;

  logic       i_write;
  logic       i_read;
  logic [1:0] done_write;
  logic [1:0] done_read;

  rotator_cfg_pkg::rotation_cfg_t ref_cfg [2];

  logic          dw_s_valid;
  logic          dw_s_ready;
  logic          dw_m_valid;
  logic [MW-1:0] dw_m_data;
  logic          dw_m_last;

  logic [1:0]    bram_clear;
  logic [1:0]    bram_wen;
  logic [1:0]    bram_ren;
  logic [MW-1:0] bram_wdata;
  logic [MW-1:0] bram_rdata [2];

  logic                        cnt_last;
  rotator_stream_pkg::w_user_t cnt_user;
  read_tag_t                   tag_in;
  read_tag_t                   tags [RAM_LATENCY];

  wire s_fire      = i_s_valid && o_s_ready;
  wire ref_fire    = s_fire && (state_dw == DW_BLOCK);
  wire dw_m_ready  = state_write == W_WRITE;
  wire dw_last_out = dw_m_valid && dw_m_ready && dw_m_last;
  wire take_bank   = (state_read == R_IDLE) && done_write[i_read];
  wire ren         = ((state_read == R_PASS_CONFIG) || (state_read == R_READ)) &&
                     i_w_slots_free && i_w_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_write <= W_IDLE;
    end else begin
      case (state_write)
        W_IDLE:    if (done_read[i_write]) state_write <= W_GET_REF;
        W_GET_REF: if (ref_fire) state_write <= W_WRITE;
        W_WRITE:   if (dw_last_out) state_write <= W_FILL;
        W_FILL:    state_write <= W_SWITCH;
        W_SWITCH:  state_write <= W_IDLE;
        default:   state_write <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_read <= R_IDLE;
    end else begin
      case (state_read)
        R_IDLE:        if (done_write[i_read]) state_read <= R_PASS_CONFIG;
        R_PASS_CONFIG: if (ren) state_read <= R_READ;
        R_READ:        if (ren && cnt_last) state_read <= R_SWITCH;
        R_SWITCH:      state_read <= R_IDLE;
        default:       state_read <= R_IDLE;
      endcase
    end
  end

  // First beat of a tensor is the config, the rest go to the adapter
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_dw <= DW_BLOCK;
    end else if (state_dw == DW_BLOCK) begin
      if (s_fire) state_dw <= DW_PASS;
    end else if (s_fire && i_s_last) begin
      state_dw <= DW_BLOCK;
    end
  end

  always_comb begin
    if (state_dw == DW_BLOCK) begin
      dw_s_valid = 1'b0;
      o_s_ready  = state_write == W_GET_REF;
    end else begin
      dw_s_valid = i_s_valid && (state_write == W_WRITE);
      o_s_ready  = dw_s_ready && (state_write == W_WRITE);
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      i_write    <= 1'b0;
      i_read     <= 1'b0;
      done_write <= 2'b00;
      done_read  <= 2'b11;
    end else begin
      if (state_write == W_SWITCH) i_write <= !i_write;
      if (state_read == R_SWITCH) i_read <= !i_read;
      if (state_write == W_GET_REF) done_write[i_write] <= 1'b0;
      if (state_write == W_SWITCH) done_write[i_write] <= 1'b1;
      if (take_bank) begin
        done_write[i_read] <= 1'b0;
        done_read[i_read]  <= 1'b0;
      end
      if (state_read == R_SWITCH) done_read[i_read] <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (ref_fire) begin
      ref_cfg[i_write] <= rotator_cfg_pkg::rotation_cfg_t'(i_s_data);
    end
  end

  // Config word goes to address 0 with zeros in the upper half
  assign bram_wdata = (state_write == W_GET_REF) ? MW'(i_s_data) : dw_m_data;

  weight_width_adapter adapter_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .i_valid (dw_s_valid),
    .o_ready (dw_s_ready),
    .i_data  (i_s_data),
    .i_last  (i_s_last),
    .o_valid (dw_m_valid),
    .i_ready (dw_m_ready),
    .o_data  (dw_m_data),
    .o_last  (dw_m_last)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    assign bram_clear[b] = (state_write == W_IDLE) && (i_write == b) && done_read[b];
    assign bram_wen[b]   = (i_write == b) && (((state_write == W_GET_REF) && ref_fire) ||
                           ((state_write == W_WRITE) && dw_m_valid));
    assign bram_ren[b]   = ren && (i_read == b);

    cyclic_bram #(
      .DEPTH    (rotator_cfg_pkg::RAM_DEPTH),
      .WIDTH    (MW),
      .LATENCY  (RAM_LATENCY),
      .ADDR_MIN (CONFIG_BEATS)
    ) bram_inst (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .i_clear    (bram_clear[b]),
      .i_wen      (bram_wen[b]),
      .i_wdata    (bram_wdata),
      .i_ren      (bram_ren[b]),
      .i_addr_max (ref_cfg[b].addr_max),
      .o_rdata    (bram_rdata[b])
    );
  end

  rotation_counters counters_inst (
    .aclk    (aclk),
    .i_load  (ref_cfg[i_read]),
    .i_start (take_bank),
    .i_step  (ren && (state_read == R_READ)),
    .o_last  (cnt_last),
    .o_user  (cnt_user)
  );

  always_comb begin
    tag_in.valid = ren;
    tag_in.bank  = i_read;
    if (state_read == R_PASS_CONFIG) begin
      tag_in.last           = 1'b0;
      tag_in.user           = '0;
      tag_in.user.is_config = 1'b1;
      tag_in.user.kw2       = ref_cfg[i_read].kw2;
    end else begin
      tag_in.last = cnt_last;
      tag_in.user = cnt_user;
    end
  end

  // Tags follow the RAM read pipe stage for stage
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < RAM_LATENCY; i++) begin
        tags[i].valid <= 1'b0;
      end
    end else begin
      tags[0] <= tag_in;
      for (int i = 1; i < RAM_LATENCY; i++) begin
        tags[i] <= tags[i-1];
      end
    end
  end

  assign o_w_valid     = tags[RAM_LATENCY-1].valid;
  assign o_w_beat.data = bram_rdata[tags[RAM_LATENCY-1].bank];
  assign o_w_beat.last = tags[RAM_LATENCY-1].last;
  assign o_w_beat.user = tags[RAM_LATENCY-1].user;

endmodule

`default_nettype wire

// File: source/conv_beat_joiner.sv
`default_nettype none

module conv_beat_joiner #(
  parameter int RAM_LATENCY = 2
) (
  input  wire                                          aclk,
  input  wire                                          aresetn,
  input  wire                                          i_w_valid,
  output logic                                         o_w_slots_free,
  input  wire  rotator_stream_pkg::w_beat_t            i_w_beat,
  input  wire                                          i_px_valid,
  output logic                                         o_px_ready,
  input  wire  [rotator_stream_pkg::PIXEL_WIDTH-1:0]   i_px_data,
  output logic                                         o_m_valid,
  input  wire                                          i_m_ready,
  output rotator_stream_pkg::conv_beat_t               o_m_beat
);

  // Room for every read that can be in flight
  localparam int DEPTH = RAM_LATENCY + 1;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  rotator_stream_pkg::w_beat_t mem [DEPTH];
  rotator_stream_pkg::w_beat_t head;

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  wire head_valid = count != '0;
  wire pop        = o_m_valid && i_m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_w_valid) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(i_w_valid) - CW'(pop);
    end
  end

  always_ff @(posedge aclk) begin
    if (i_w_valid) begin
      mem[wr_ptr] <= i_w_beat;
    end
  end

  assign head           = mem[rd_ptr];
  assign o_w_slots_free = count == '0;

  // Config beats pass alone, data beats wait for a pixel
  assign o_m_valid  = head_valid && (i_px_valid || head.user.is_config);
  assign o_px_ready = i_m_ready && head_valid && !head.user.is_config;

  assign o_m_beat.weights = head.data;
  assign o_m_beat.pixels  = head.user.is_config ? '0 : i_px_data;
  assign o_m_beat.last    = head.last;
  assign o_m_beat.user    = head.user;

endmodule

`default_nettype wire

// File: source/conv_feed_top.sv
`default_nettype none

module conv_feed_top #(
  parameter int CONFIG_BEATS = 1,
  parameter int RAM_LATENCY  = 2
) (
  input  wire                                          aclk,
  input  wire                                          aresetn,
  input  wire                                          i_s_valid,
  output logic                                         o_s_ready,
  input  wire  [rotator_cfg_pkg::S_WIDTH-1:0]          i_s_data,
  input  wire                                          i_s_last,
  input  wire                                          i_px_valid,
  output logic                                         o_px_ready,
  input  wire  [rotator_stream_pkg::PIXEL_WIDTH-1:0]   i_px_data,
  output logic                                         o_m_valid,
  input  wire                                          i_m_ready,
  output rotator_stream_pkg::conv_beat_t               o_m_beat
);

  logic                        w_valid;
  logic                        w_slots_free;
  rotator_stream_pkg::w_beat_t w_beat;

  weight_rotator #(
    .CONFIG_BEATS (CONFIG_BEATS),
    .RAM_LATENCY  (RAM_LATENCY)
  ) weight_rotator_inst (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .i_s_valid      (i_s_valid),
    .o_s_ready      (o_s_ready),
    .i_s_data       (i_s_data),
    .i_s_last       (i_s_last),
    .o_w_valid      (w_valid),
    // Joiner reserves space before each read, so it always accepts
    .i_w_ready      (1'b1),
    .o_w_beat       (w_beat),
    .i_w_slots_free (w_slots_free)
  );

  conv_beat_joiner #(
    .RAM_LATENCY (RAM_LATENCY)
  ) conv_beat_joiner_inst (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .i_w_valid      (w_valid),
    .o_w_slots_free (w_slots_free),
    .i_w_beat       (w_beat),
    .i_px_valid     (i_px_valid),
    .o_px_ready     (o_px_ready),
    .i_px_data      (i_px_data),
    .o_m_valid      (o_m_valid),
    .i_m_ready      (i_m_ready),
    .o_m_beat       (o_m_beat)
  );

endmodule

`default_nettype wire

// File: bench/tb_conv_feed.sv
`default_nettype none

module tb_conv_feed;

  localparam int CONFIG_BEATS = 1;
  localparam int RAM_LATENCY  = 2;
  localparam int NUM_TENSORS  = 4;

  typedef struct {
    int kw2;
    int cin_1;
    int cols_1;
    int blocks_1;
    int xn_1;
    int out_beats;
  } tensor_row_t;

  logic                                          aclk = 1'b0;
  logic                                          aresetn;
  logic                                          i_s_valid;
  logic                                          o_s_ready;
  logic [rotator_cfg_pkg::S_WIDTH-1:0]           i_s_data;
  logic                                          i_s_last;
  logic                                          i_px_valid;
  logic                                          o_px_ready;
  logic [rotator_stream_pkg::PIXEL_WIDTH-1:0]    i_px_data;
  logic                                          o_m_valid;
  logic                                          i_m_ready;
  rotator_stream_pkg::conv_beat_t                o_m_beat;

  tensor_row_t                    rows [NUM_TENSORS];
  logic [15:0]                    in_data_q [$];
  logic                           in_last_q [$];
  rotator_stream_pkg::conv_beat_t exp_q [$];

  int   seed = 57976;
  int   exp_total = 0;
  int   px_model = 0;
  int   first_last_idx = 0;
  logic model_ready = 1'b0;
  logic first_loaded = 1'b0;

  always #4 aclk = !aclk;

  conv_feed_top #(
    .CONFIG_BEATS (CONFIG_BEATS),
    .RAM_LATENCY  (RAM_LATENCY)
  ) conv_feed_top_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_s_valid  (i_s_valid),
    .o_s_ready  (o_s_ready),
    .i_s_data   (i_s_data),
    .i_s_last   (i_s_last),
    .i_px_valid (i_px_valid),
    .o_px_ready (o_px_ready),
    .i_px_data  (i_px_data),
    .o_m_valid  (o_m_valid),
    .i_m_ready  (i_m_ready),
    .o_m_beat   (o_m_beat)
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic set_row(input int idx, input int kw2, input int cin_1, input int cols_1,
                         input int blocks_1, input int xn_1, input int out_beats);
    rows[idx].kw2       = kw2;
    rows[idx].cin_1     = cin_1;
    rows[idx].cols_1    = cols_1;
    rows[idx].blocks_1  = blocks_1;
    rows[idx].xn_1      = xn_1;
    rows[idx].out_beats = out_beats;
  endtask

  task automatic load_table();
    // kw2, cin_1, cols_1, blocks_1, xn_1, output beats including the config beat
    set_row(0, 1, 1, 2, 1, 0, 37);
    set_row(1, 0, 0, 0, 0, 0, 2);
    set_row(2, 3, 3, 1, 0, 1, 113);
    set_row(3, 2, 0, 7, 3, 1, 321);
  endtask

  // Input beats and the expected output stream of one tensor
  task automatic build_tensor(input int t);
    rotator_cfg_pkg::rotation_cfg_t cfg;
    rotator_stream_pkg::conv_beat_t exp;
    logic [15:0] beats [$];
    logic [31:0] words [$];
    int k_len;
    int c_len;
    int n_words;
    int n_reads;
    int c_kw;
    int c_ci;
    int c_cols;
    k_len   = 2 * rows[t].kw2 + 1;
    c_len   = rows[t].cin_1 + 1;
    n_words = k_len * c_len;
    n_reads = rows[t].out_beats - 1;
    cfg          = '0;
    cfg.kw2      = rotator_cfg_pkg::BITS_KW2'(rows[t].kw2);
    cfg.cin_1    = rotator_cfg_pkg::BITS_CI'(rows[t].cin_1);
    cfg.cols_1   = rotator_cfg_pkg::BITS_XW'(rows[t].cols_1);
    cfg.blocks_1 = rotator_cfg_pkg::BITS_BLOCKS'(rows[t].blocks_1);
    cfg.xn_1     = rotator_cfg_pkg::BITS_XN'(rows[t].xn_1);
    cfg.addr_max = rotator_cfg_pkg::BITS_ADDR'(CONFIG_BEATS + n_words - 1);
    in_data_q.push_back(16'(cfg));
    in_last_q.push_back(1'b0);
    exp                = '0;
    exp.weights        = 32'(16'(cfg));
    exp.user.is_config = 1'b1;
    exp.user.kw2       = cfg.kw2;
    exp_q.push_back(exp);
    for (int i = 0; i < 2 * n_words; i++) begin
      beats.push_back(16'($random(seed)));
      in_data_q.push_back(beats[i]);
      in_last_q.push_back(i == 2 * n_words - 1);
    end
    for (int j = 0; j < n_words; j++) begin
      words.push_back({beats[2 * j + 1], beats[2 * j]});
    end
    for (int k = 0; k < n_reads; k++) begin
      c_kw   = k % k_len;
      c_ci   = (k / k_len) % c_len;
      c_cols = (k / n_words) % (rows[t].cols_1 + 1);
      exp                     = '0;
      exp.weights             = words[k % n_words];
      exp.pixels              = px_model;
      exp.last                = k == n_reads - 1;
      exp.user.kw2            = cfg.kw2;
      exp.user.is_w_first_clk = (c_kw == 0) && (c_ci == 0) && (c_cols == 0);
      exp.user.is_cin_last    = (c_kw == k_len - 1) && (c_ci == c_len - 1);
      exp.user.is_w_first_kw2 = (rows[t].cols_1 - c_cols) < rows[t].kw2;
      exp.user.is_w_last      = c_cols == rows[t].cols_1;
      exp_q.push_back(exp);
      px_model++;
    end
    exp_total += n_reads + 1;
  endtask

  task automatic send_beat(input logic [15:0] data, input logic last);
    while (({$random(seed)} % 4) == 0) begin
      @(posedge aclk);
      #1;
    end
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    while (!o_s_ready) begin
      @(posedge aclk);
      #1;
    end
    @(posedge aclk);
    #1;
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic check_output();
    rotator_stream_pkg::conv_beat_t exp;
    // Nothing may come out before the first tensor is in RAM
    if (!first_loaded) begin
      check_value("o_m_valid", o_m_valid, 1'b0);
    end
    if (o_m_valid && i_m_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output beat at %0t arrived when no beat was expected", $time);
        $display("sim failed");
        $fatal(1, "Extra output beat");
      end
      exp = exp_q.pop_front();
      check_value("o_m_beat.weights", o_m_beat.weights, exp.weights);
      check_value("o_m_beat.pixels", o_m_beat.pixels, exp.pixels);
      check_value("o_m_beat.last", o_m_beat.last, exp.last);
      check_value("o_m_beat.user.is_config", o_m_beat.user.is_config, exp.user.is_config);
      check_value("o_m_beat.user.kw2", o_m_beat.user.kw2, exp.user.kw2);
      check_value("o_m_beat.user.is_w_first_clk", o_m_beat.user.is_w_first_clk,
                  exp.user.is_w_first_clk);
      check_value("o_m_beat.user.is_cin_last", o_m_beat.user.is_cin_last,
                  exp.user.is_cin_last);
      check_value("o_m_beat.user.is_w_first_kw2", o_m_beat.user.is_w_first_kw2,
                  exp.user.is_w_first_kw2);
      check_value("o_m_beat.user.is_w_last", o_m_beat.user.is_w_last, exp.user.is_w_last);
    end
  endtask

  // Pixel counter and random back-pressure on the output
  initial begin
    logic px_fire;
    px_fire    = 1'b0;
    i_px_valid = 1'b1;
    i_px_data  = '0;
    i_m_ready  = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      if (px_fire) begin
        i_px_data = i_px_data + 1;
      end
      i_m_ready = ({$random(seed)} % 4) != 0;
      // Outputs settle by mid cycle and transfer on the next rising edge
      @(negedge aclk);
      px_fire = aresetn && o_px_ready && i_px_valid;
      if (aresetn) begin
        check_output();
      end
    end
  end

  initial begin
    aresetn   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    load_table();
    for (int t = 0; t < NUM_TENSORS; t++) begin
      build_tensor(t);
      if (t == 0) begin
        first_last_idx = in_data_q.size() - 1;
      end
    end
    model_ready = 1'b1;
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    for (int i = 0; i < in_data_q.size(); i++) begin
      send_beat(in_data_q[i], in_last_q[i]);
      if (i == first_last_idx) begin
        first_loaded = 1'b1;
      end
    end
    while (exp_q.size() != 0) begin
      @(posedge aclk);
    end
    // Quiet tail catches any extra beat
    repeat (50) @(posedge aclk);
    $display("sim passed");
    $finish;
  end

  initial begin
    wait (model_ready);
    repeat (10 + 40 * exp_total) @(posedge aclk);
    $display("Timeout with %0d output beats still outstanding", exp_q.size());
    $display("sim failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: tb.f
common/rotator_cfg_pkg.sv
common/rotator_stream_pkg.sv
source/weight_width_adapter.sv
source/cyclic_bram.sv
source/rotation_counters.sv
weight_rotator/weight_rotator.sv
source/conv_beat_joiner.sv
source/conv_feed_top.sv
bench/tb_conv_feed.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the conv feeder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_conv_feed -o tb_conv_feed

./obj_dir/tb_conv_feed 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation completed"
